/* icache_top.f */
hw/icache_pkg.sv
hw/mem_pkg.sv
hw/icache_store.sv
hw/icache_lookup.sv
hw/icache_refill.sv
hw/icache_top.sv
tb/tb_icache_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f icache_top.f --top-module tb_icache_top

sim_out=$(./obj_dir/Vtb_icache_top)
echo "$sim_out"

if grep -q "^Done: no errors$" <<< "$sim_out"; then
  exit 0
fi
exit 1

/* tb/tb_icache_top.sv */
// Instruction cache testbench
module tb_icache_top;

  localparam int SETS = 8;
  localparam int SET_BITS = $clog2(SETS);
  localparam int TAG_BITS = icache_pkg::LINE_ADDR_BITS - SET_BITS;
  localparam int RANDOM_CYCLES = 3000;
  // Each access may wait out a full refill with margin on top
  localparam int TIMEOUT_CYCLES = RANDOM_CYCLES * 8 + 6000;
  localparam logic [26:0] LINE_BASE = 27'h1234500;

  logic cs = 1'b0;
  logic i_arst_n;
  logic [31:0] i_addr_0;
  logic [31:0] i_addr_1;
  logic i_read_0;
  logic i_read_1;
  logic [31:0] o_instr_0;
  logic [31:0] o_instr_1;
  logic o_hit_0;
  logic o_hit_1;
  logic o_mem_read;
  logic [31:0] o_mem_addr;
  logic i_mem_ready;
  logic [255:0] i_mem_data;

  logic [31:0] rng_state;
  logic [TAG_BITS-1:0] model_tag [SETS];
  logic model_valid [SETS];
  logic model_fetch;
  logic [31:0] model_req;
  logic mem_busy;
  int mem_count;
  logic last_hit_0;
  logic last_hit_1;
  logic last_mem_read;
  logic [31:0] last_mem_addr;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  int cycle_count = 0;

  icache_top #(.SETS(SETS)) UUT (
    .cs(cs), .i_arst_n(i_arst_n),
    .i_addr_0(i_addr_0), .i_read_0(i_read_0), .o_instr_0(o_instr_0), .o_hit_0(o_hit_0),
    .i_addr_1(i_addr_1), .i_read_1(i_read_1), .o_instr_1(o_instr_1), .o_hit_1(o_hit_1),
    .o_mem_read(o_mem_read), .o_mem_addr(o_mem_addr),
    .i_mem_ready(i_mem_ready), .i_mem_data(i_mem_data)
  );

  always #10 cs = ~cs;

  always @(posedge cs) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Low half is the address, high half its inverted top bits
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {~a[31:16], a[15:0]};
  endfunction

  // Word 0 of the line goes in the top bits
  function automatic logic [255:0] mem_line(input logic [31:0] base);
    logic [255:0] line;
    for (int w = 0; w < 8; w++) begin
      line[255 - 32 * w -: 32] = mem_word(base + 32'(4 * w));
    end
    return line;
  endfunction

  function automatic logic [31:0] pool_addr(input int idx, input logic [2:0] word);
    return {LINE_BASE + 27'(idx * 3), word, 2'b00};
  endfunction

  function automatic logic [31:0] line_of(input logic [31:0] a);
    return {a[31:5], 5'b0};
  endfunction

  function automatic logic model_hit(input logic [31:0] a);
    return model_valid[a[5 +: SET_BITS]] && (model_tag[a[5 +: SET_BITS]] == a[31 -: TAG_BITS]);
  endfunction

  task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error: %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_port(input string port, input logic exp_hit, input logic [31:0] addr,
                            input logic hit, input logic [31:0] instr);
    logic [31:0] exp_instr;
    exp_instr = exp_hit ? mem_word({addr[31:2], 2'b00}) : 32'h0;
    expect_value({"o_hit_", port}, 32'(exp_hit), 32'(hit));
    expect_value({"o_instr_", port}, exp_instr, instr);
  endtask

  // One clock with checks at the falling edge and model updates at the rising edge
  task automatic step();
    logic hit_0;
    logic hit_1;
    logic miss_0;
    logic miss_1;
    logic ready_s;
    logic [31:0] addr_0;
    logic [31:0] addr_1;
    @(negedge cs);
    addr_0 = i_addr_0;
    addr_1 = i_addr_1;
    hit_0 = i_read_0 && model_hit(addr_0);
    hit_1 = i_read_1 && model_hit(addr_1);
    miss_0 = i_read_0 && !hit_0;
    miss_1 = i_read_1 && !hit_1;
    check_port("0", hit_0, addr_0, o_hit_0, o_instr_0);
    check_port("1", hit_1, addr_1, o_hit_1, o_instr_1);
    expect_value("o_mem_read", 32'(model_fetch), 32'(o_mem_read));
    expect_value("o_mem_addr", model_req, o_mem_addr);
    last_hit_0 = o_hit_0;
    last_hit_1 = o_hit_1;
    last_mem_read = o_mem_read;
    last_mem_addr = o_mem_addr;
    ready_s = i_mem_ready;
    @(posedge cs);
    if (!model_fetch) begin
      if (miss_0 || miss_1) begin
        model_fetch = 1'b1;
        model_req = line_of(miss_0 ? addr_0 : addr_1);
      end
    end else if (ready_s) begin
      model_fetch = 1'b0;
      model_valid[model_req[5 +: SET_BITS]] = 1'b1;
      model_tag[model_req[5 +: SET_BITS]] = model_req[31 -: TAG_BITS];
    end
    // Memory answers each request after 1 to 6 cycles
    if (ready_s) begin
      i_mem_ready <= 1'b0;
      mem_busy = 1'b0;
    end else if (last_mem_read && !mem_busy) begin
      mem_busy = 1'b1;
      mem_count = 1 + int'(next_rand() % 32'd6);
    end
    if (mem_busy && !ready_s) begin
      mem_count--;
      if (mem_count == 0) begin
        i_mem_ready <= 1'b1;
        i_mem_data <= mem_line(last_mem_addr);
      end
    end
  endtask

  // Run until the wanted ports hit and check the first request address
  task automatic wait_hits(input logic need_1, input logic [31:0] first_line);
    logic seen;
    seen = 1'b0;
    do begin
      step();
      if (last_mem_read && !seen) begin
        seen = 1'b1;
        expect_value("o_mem_addr", first_line, last_mem_addr);
      end
    end while (!(last_hit_0 && (last_hit_1 || !need_1)));
    assert (seen) else begin
      $display("No memory request was seen before the hit");
      errors++;
    end
  endtask

  task automatic drain();
    i_read_0 <= 1'b0;
    i_read_1 <= 1'b0;
    do begin
      step();
    end while (last_mem_read);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", tests_run, name, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  initial begin
    int i;
    int overlap;
    logic [31:0] r;
    i_arst_n = 1'b0;
    i_addr_0 = '0;
    i_addr_1 = '0;
    i_read_0 = 1'b0;
    i_read_1 = 1'b0;
    i_mem_ready = 1'b0;
    i_mem_data = '0;
    rng_state = 32'd78563;
    for (i = 0; i < SETS; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i] = '0;
    end
    model_fetch = 1'b0;
    model_req = '0;
    mem_busy = 1'b0;
    mem_count = 0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;

    // Reads are on in the first reset cycle and off before release
    for (i = 0; i < 2; i++) begin
      @(posedge cs);
      i_read_0 <= (i == 0);
      i_read_1 <= (i == 0);
      i_addr_0 <= pool_addr(i, 3'd2);
      i_addr_1 <= pool_addr(i + 7, 3'd5);
      @(negedge cs);
      expect_value("o_hit_0", 32'h0, 32'(o_hit_0));
      expect_value("o_hit_1", 32'h0, 32'(o_hit_1));
      expect_value("o_mem_read", 32'h0, 32'(o_mem_read));
      expect_value("o_mem_addr", 32'h0, o_mem_addr);
    end
    @(posedge cs);
    i_arst_n <= 1'b1;
    step();
    finish_test("reset state");

    i_read_0 <= 1'b1;
    i_addr_0 <= pool_addr(0, 3'd3);
    wait_hits(1'b0, line_of(pool_addr(0, 3'd0)));
    finish_test("first miss and refill");

    for (i = 0; i < 8; i++) begin
      i_read_0 <= 1'b1;
      i_read_1 <= 1'b0;
      i_addr_0 <= pool_addr(0, 3'(i));
      step();
      i_read_0 <= 1'b0;
      i_read_1 <= 1'b1;
      i_addr_1 <= pool_addr(0, 3'(i));
      step();
    end
    finish_test("all words of a line");

    i_read_0 <= 1'b1;
    i_read_1 <= 1'b1;
    i_addr_0 <= pool_addr(1, 3'd0);
    i_addr_1 <= pool_addr(2, 3'd4);
    wait_hits(1'b1, line_of(pool_addr(1, 3'd0)));
    finish_test("port 0 priority");

    // Port 0 opens a refill, then both ports read valid lines
    i_addr_0 <= pool_addr(5, 3'd0);
    i_addr_1 <= pool_addr(0, 3'd1);
    step();
    overlap = 0;
    for (i = 0; i < 6; i++) begin
      i_addr_0 <= pool_addr(0, 3'(i));
      i_addr_1 <= pool_addr(1, 3'(i + 2));
      step();
      if (last_mem_read && last_hit_0 && last_hit_1) begin
        overlap++;
      end
    end
    assert (overlap > 0) else begin
      $display("Both ports never hit together while a refill was open");
      errors++;
    end
    drain();
    finish_test("dual hit during refill");

    for (i = 0; i < RANDOM_CYCLES; i++) begin
      r = next_rand();
      i_read_0 <= r[0];
      i_read_1 <= r[1];
      i_addr_0 <= pool_addr(int'(r[15:8]) % 48, r[18:16]);
      i_addr_1 <= pool_addr(int'(r[27:20]) % 48, r[30:28]);
      step();
    end
    drain();
    finish_test("random access");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* hw/icache_top.sv */
// Two port instruction cache
module icache_top #(
  parameter int SETS = icache_pkg::DEFAULT_SETS
) (
  input  logic                          cs,
  input  logic                          i_arst_n,

  input  logic [mem_pkg::WORD_BITS-1:0] i_addr_0,
  input  logic                          i_read_0,
  output logic [mem_pkg::WORD_BITS-1:0] o_instr_0,
  output logic                          o_hit_0,

  input  logic [mem_pkg::WORD_BITS-1:0] i_addr_1,
  input  logic                          i_read_1,
  output logic [mem_pkg::WORD_BITS-1:0] o_instr_1,
  output logic                          o_hit_1,

  output logic                          o_mem_read,
  output logic [mem_pkg::WORD_BITS-1:0] o_mem_addr,
  input  logic                          i_mem_ready,
  input  logic [mem_pkg::LINE_BITS-1:0] i_mem_data
);

  localparam int SET_BITS = $clog2(SETS);
  localparam int TAG_BITS = icache_pkg::LINE_ADDR_BITS - SET_BITS;

  // Read views
  logic [SET_BITS-1:0]           rd_set_0;
  logic [SET_BITS-1:0]           rd_set_1;
  logic [TAG_BITS-1:0]           rd_tag_0;
  logic [TAG_BITS-1:0]           rd_tag_1;
  icache_pkg::line_state_e       rd_state_0;
  icache_pkg::line_state_e       rd_state_1;
  logic [mem_pkg::LINE_BITS-1:0] rd_line_0;
  logic [mem_pkg::LINE_BITS-1:0] rd_line_1;

  logic miss_0;
  logic miss_1;

  // Refill write
  logic                          wr_en;
  logic [SET_BITS-1:0]           wr_set;
  logic [TAG_BITS-1:0]           wr_tag;
  logic [mem_pkg::LINE_BITS-1:0] wr_line;

  icache_store #(.SETS(SETS)) u_store (
    .cs          (cs),
    .i_arst_n    (i_arst_n),
    .i_rd_set_0  (rd_set_0),
    .i_rd_set_1  (rd_set_1),
    .o_rd_tag_0  (rd_tag_0),
    .o_rd_tag_1  (rd_tag_1),
    .o_rd_state_0(rd_state_0),
    .o_rd_state_1(rd_state_1),
    .o_rd_line_0 (rd_line_0),
    .o_rd_line_1 (rd_line_1),
    .i_wr_en     (wr_en),
    .i_wr_set    (wr_set),
    .i_wr_tag    (wr_tag),
    .i_wr_line   (wr_line)
  );

  icache_lookup #(.SETS(SETS)) u_lookup_0 (
    .i_addr (i_addr_0),
    .i_read (i_read_0),
    .o_set  (rd_set_0),
    .i_tag  (rd_tag_0),
    .i_state(rd_state_0),
    .i_line (rd_line_0),
    .o_instr(o_instr_0),
    .o_hit  (o_hit_0),
    .o_miss (miss_0)
  );

  icache_lookup #(.SETS(SETS)) u_lookup_1 (
    .i_addr (i_addr_1),
    .i_read (i_read_1),
    .o_set  (rd_set_1),
    .i_tag  (rd_tag_1),
    .i_state(rd_state_1),
    .i_line (rd_line_1),
    .o_instr(o_instr_1),
    .o_hit  (o_hit_1),
    .o_miss (miss_1)
  );

  icache_refill #(.SETS(SETS)) u_refill (
    .cs         (cs),
    .i_arst_n   (i_arst_n),
    .i_addr_0   (i_addr_0),
    .i_addr_1   (i_addr_1),
    .i_miss_0   (miss_0),
    .i_miss_1   (miss_1),
    .i_mem_ready(i_mem_ready),
    .i_mem_data (i_mem_data),
    .o_mem_read (o_mem_read),
    .o_mem_addr (o_mem_addr),
    .o_wr_en    (wr_en),
    .o_wr_set   (wr_set),
    .o_wr_tag   (wr_tag),
    .o_wr_line  (wr_line)
  );

endmodule

/* hw/icache_refill.sv */
// Miss arbitration and line refill
module icache_refill #(
  parameter int SETS = 8
) (
  input  logic                                               cs,
  input  logic                                               i_arst_n,

  input  logic [mem_pkg::WORD_BITS-1:0]                      i_addr_0,
  input  logic [mem_pkg::WORD_BITS-1:0]                      i_addr_1,
  input  logic                                               i_miss_0,
  input  logic                                               i_miss_1,

  input  logic                                               i_mem_ready,
  input  logic [mem_pkg::LINE_BITS-1:0]                      i_mem_data,
  output logic                                               o_mem_read,
  output logic [mem_pkg::WORD_BITS-1:0]                      o_mem_addr,

  output logic                                               o_wr_en,
  output logic [$clog2(SETS)-1:0]                            o_wr_set,
  output logic [icache_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] o_wr_tag,
  output logic [mem_pkg::LINE_BITS-1:0]                      o_wr_line
);

  localparam int SET_BITS = $clog2(SETS);

  icache_pkg::fetch_addr_u miss_addr;
  icache_pkg::fetch_addr_u req_q;
  logic fetching_q;
  logic any_miss;
  logic line_done;

  // Port 0 wins when both miss
  assign miss_addr.flat = i_miss_0 ? i_addr_0 : i_addr_1;
  assign any_miss       = i_miss_0 | i_miss_1;

  // Ready only counts while a request is open
  assign line_done = fetching_q & i_mem_ready;

  // Idle when low, fetching when high
  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fetching_q <= 1'b0;
      req_q.flat <= '0;
    end else if (!fetching_q) begin
      if (any_miss) begin
        fetching_q     <= 1'b1;
        req_q.f.line   <= miss_addr.f.line;
        req_q.f.word   <= '0;
        req_q.f.offset <= '0;
      end
    end else if (line_done) begin
      fetching_q <= 1'b0;
    end
  end

  assign o_mem_read = fetching_q;
  assign o_mem_addr = req_q.flat;

  // Write lands on the ready edge
  assign o_wr_en   = line_done;
  assign o_wr_set  = req_q.f.line[SET_BITS-1:0];
  assign o_wr_tag  = req_q.f.line[icache_pkg::LINE_ADDR_BITS-1:SET_BITS];
  assign o_wr_line = i_mem_data;

endmodule

/* hw/icache_lookup.sv */
// Single port cache lookup
module icache_lookup #(
  parameter int SETS = 8
) (
  input  logic [mem_pkg::WORD_BITS-1:0]                      i_addr,
  input  logic                                               i_read,

  output logic [$clog2(SETS)-1:0]                            o_set,
  input  logic [icache_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] i_tag,
  input  icache_pkg::line_state_e                            i_state,
  input  logic [mem_pkg::LINE_BITS-1:0]                      i_line,

  output logic [mem_pkg::WORD_BITS-1:0]                      o_instr,
  output logic                                               o_hit,
  output logic                                               o_miss
);

  localparam int SET_BITS = $clog2(SETS);
  localparam int TAG_BITS = icache_pkg::LINE_ADDR_BITS - SET_BITS;

  icache_pkg::fetch_addr_u addr;
  logic [TAG_BITS-1:0] addr_tag;
  logic [0:mem_pkg::WORDS_PER_LINE-1][mem_pkg::WORD_BITS-1:0] words;
  logic tag_match;

  assign addr.flat = i_addr;

  // Set index is the low part of the line address, tag the rest
  assign o_set    = addr.f.line[SET_BITS-1:0];
  assign addr_tag = addr.f.line[icache_pkg::LINE_ADDR_BITS-1:SET_BITS];

  assign words     = i_line;
  assign tag_match = (addr_tag == i_tag);

  always_comb begin
    o_hit   = 1'b0;
    o_miss  = 1'b0;
    o_instr = '0;
    if (i_read) begin
      if (tag_match && (i_state == icache_pkg::VALID)) begin
        o_hit   = 1'b1;
        o_instr = words[addr.f.word];
      end else begin
        // Raise a miss level until refill lands the line
        o_miss = 1'b1;
      end
    end
  end

endmodule

/* hw/icache_store.sv */
// Cache set storage
module icache_store #(
  parameter int SETS = 8
) (
  input  logic                                         cs,
  input  logic                                         i_arst_n,

  input  logic [$clog2(SETS)-1:0]                      i_rd_set_0,
  input  logic [$clog2(SETS)-1:0]                      i_rd_set_1,
  output logic [icache_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] o_rd_tag_0,
  output logic [icache_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] o_rd_tag_1,
  output icache_pkg::line_state_e                      o_rd_state_0,
  output icache_pkg::line_state_e                      o_rd_state_1,
  output logic [mem_pkg::LINE_BITS-1:0]                o_rd_line_0,
  output logic [mem_pkg::LINE_BITS-1:0]                o_rd_line_1,

  input  logic                                         i_wr_en,
  input  logic [$clog2(SETS)-1:0]                      i_wr_set,
  input  logic [icache_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] i_wr_tag,
  input  logic [mem_pkg::LINE_BITS-1:0]                i_wr_line
);

  localparam int SET_BITS = $clog2(SETS);
  localparam int TAG_BITS = icache_pkg::LINE_ADDR_BITS - SET_BITS;

  logic [TAG_BITS-1:0] tag_q [SETS];
  logic [0:mem_pkg::WORDS_PER_LINE-1][mem_pkg::WORD_BITS-1:0] data_q [SETS];
  icache_pkg::line_state_e state_q [SETS];

  // Every line starts INVALID after reset
  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int s = 0; s < SETS; s++) begin
        state_q[s] <= icache_pkg::INVALID;
      end
    end else if (i_wr_en) begin
      state_q[i_wr_set] <= icache_pkg::VALID;
    end
  end

  // Refill replaces tag and line of one set
  always_ff @(posedge cs) begin
    if (i_wr_en) begin
      tag_q[i_wr_set]  <= i_wr_tag;
      data_q[i_wr_set] <= i_wr_line;
    end
  end

  // Read views for the two lookup ports
  assign o_rd_tag_0   = tag_q[i_rd_set_0];
  assign o_rd_state_0 = state_q[i_rd_set_0];
  assign o_rd_line_0  = data_q[i_rd_set_0];

  assign o_rd_tag_1   = tag_q[i_rd_set_1];
  assign o_rd_state_1 = state_q[i_rd_set_1];
  assign o_rd_line_1  = data_q[i_rd_set_1];

endmodule

/* hw/mem_pkg.sv */
// Memory side widths
package mem_pkg;

  // One instruction word
  localparam int WORD_BITS = 32;

  // Words moved per refill
  localparam int WORDS_PER_LINE = 8;

  // Whole line as it crosses the memory bus
  // Word 0 sits in the top bits, word 7 in the bottom bits
  localparam int LINE_BITS = WORD_BITS * WORDS_PER_LINE;

endpackage

/* hw/icache_pkg.sv */
// Instruction cache definitions
package icache_pkg;

  // Default number of sets for the top level
  localparam int DEFAULT_SETS = 8;

  // Fetch address split
  localparam int ADDR_BITS = 32;
  localparam int LINE_ADDR_BITS = 27;
  localparam int WORD_IDX_BITS = 3;
  localparam int BYTE_OFF_BITS = 2;

  // Per-set line state
  typedef enum logic {
    INVALID = 1'b0,
    VALID   = 1'b1
  } line_state_e;

  // Field view of a fetch address
  // The line address holds the tag above the set index
  typedef struct packed {
    logic [LINE_ADDR_BITS-1:0] line;
    logic [WORD_IDX_BITS-1:0]  word;
    logic [BYTE_OFF_BITS-1:0]  offset;
  } fetch_fields_t;

  // The same 32 bits read flat or by fields
  typedef union packed {
    logic [ADDR_BITS-1:0] flat;
    fetch_fields_t        f;
  } fetch_addr_u;

endpackage
